// File: sources.f
design/spi_link_pkg.sv
design/attitude_pkg.sv
design/frame_if.sv
design/spi_frame_receiver.sv
design/frame_capture.sv
design/frame_decoder.sv
design/attitude_output.sv
design/imu_spi_link_top.sv
testbench/imu_spi_link_properties.sv
testbench/tb_imu_spi_link.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_imu_spi_link \
    -f sources.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && grep -q "Testbench passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass, see build.log and sim.log"; exit 1; }

// File: testbench/tb_imu_spi_link.sv
`default_nettype none
`timescale 1ns/10ps

// Testbench for the SPI attitude link
// Packets go out in SPI mode 0 and all outputs are compared with a model after each one
module tb_imu_spi_link;
    import spi_link_pkg::*;
    import attitude_pkg::*;

    localparam int    SETTLE_CYCLES = 3;
    localparam byte_t HEADER_BYTE   = 8'hAA;
    localparam int    CLK_PERIOD    = 20;
    localparam int    PACKET_COUNT  = 26;
    // Every bit takes eight clk cycles, plus room per packet for select and settling
    localparam int WATCHDOG_NS = PACKET_COUNT * (16 * 8 * 8 * CLK_PERIOD + 40 * CLK_PERIOD)
                                 + 100 * CLK_PERIOD;

    // Everything the DUT shows to its consumer
    typedef struct packed {
        logic    initialized;
        logic    error;
        logic    quat1_valid;
        logic    gyro1_valid;
        sample_t quat1_w;
        sample_t quat1_x;
        sample_t quat1_y;
        sample_t quat1_z;
        sample_t gyro1_x;
        sample_t gyro1_y;
        sample_t gyro1_z;
    } expected_t;

    logic    clk;
    logic    cs_n;
    logic    ss_n;
    logic    sck;
    logic    sdi;
    logic    initialized;
    logic    error;
    logic    quat1_valid;
    logic    gyro1_valid;
    sample_t quat1_w;
    sample_t quat1_x;
    sample_t quat1_y;
    sample_t quat1_z;
    sample_t gyro1_x;
    sample_t gyro1_y;
    sample_t gyro1_z;

    int        seed = 16408;
    int        errors = 0;
    int        pushed_count = 0;
    int        checks_done = 0;
    expected_t model_state;
    expected_t expected_q[$];

    imu_spi_link_top #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .HEADER_BYTE   (HEADER_BYTE)
    ) dut0 (
        .clk (clk), .cs_n (cs_n), .ss_n (ss_n), .sck (sck), .sdi (sdi),
        .initialized (initialized), .error (error),
        .quat1_valid (quat1_valid), .gyro1_valid (gyro1_valid),
        .quat1_w (quat1_w), .quat1_x (quat1_x), .quat1_y (quat1_y), .quat1_z (quat1_z),
        .gyro1_x (gyro1_x), .gyro1_y (gyro1_y), .gyro1_z (gyro1_z)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================
    // Reference model and packet helpers
    // ========================================

    // Applies one packet to the previous output state
    // A bad header only touches the status bits
    function automatic expected_t predict_outputs(input packet_t pkt, input expected_t prev);
        expected_t next;
        next = prev;
        if (pkt[0] == HEADER_BYTE) begin
            next.quat1_w     = 16'sd16384;
            next.quat1_x     = {pkt[1], pkt[2]};
            next.quat1_y     = {pkt[3], pkt[4]};
            next.quat1_z     = {pkt[5], pkt[6]};
            next.gyro1_x     = {pkt[7], pkt[8]};
            next.gyro1_y     = {pkt[9], pkt[10]};
            next.gyro1_z     = {pkt[11], pkt[12]};
            next.quat1_valid = pkt[13][0];
            next.gyro1_valid = pkt[13][1];
            next.initialized = 1'b1;
            next.error       = 1'b0;
        end else begin
            next.initialized = 1'b0;
            next.error       = 1'b1;
        end
        return next;
    endfunction

    // Lays out a packet with each 16-bit field MSB byte first
    function automatic packet_t build_packet(input byte_t header, input sample_t roll,
                                             input sample_t pitch, input sample_t yaw,
                                             input sample_t gx, input sample_t gy,
                                             input sample_t gz, input byte_t flags,
                                             input logic [15:0] reserved);
        packet_t pkt;
        pkt[0] = header;
        {pkt[1], pkt[2]} = roll;
        {pkt[3], pkt[4]} = pitch;
        {pkt[5], pkt[6]} = yaw;
        {pkt[7], pkt[8]} = gx;
        {pkt[9], pkt[10]} = gy;
        {pkt[11], pkt[12]} = gz;
        pkt[13] = flags;
        {pkt[14], pkt[15]} = reserved;
        return pkt;
    endfunction

    function automatic logic [15:0] random_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // ========================================
    // SPI stimulus
    // ========================================

    // Mode 0 with sck low then high for four clk cycles each, MSB first
    task automatic send_packet(input packet_t pkt);
        int b;
        int k;
        @(posedge clk);
        ss_n <= 1'b0;
        repeat (4) @(posedge clk);
        for (b = 0; b < PACKET_BYTES; b++) begin
            for (k = 7; k >= 0; k--) begin
                sck <= 1'b0;
                sdi <= pkt[b][k];
                repeat (4) @(posedge clk);
                sck <= 1'b1;
                repeat (4) @(posedge clk);
            end
        end
        sck <= 1'b0;
        repeat (4) @(posedge clk);
        ss_n <= 1'b1;
        repeat (SETTLE_CYCLES + 10) @(posedge clk);
    endtask

    // Sends a packet and hands the predicted outputs to the compare process
    task automatic run_packet(input packet_t pkt);
        send_packet(pkt);
        model_state = predict_outputs(pkt, model_state);
        expected_q.push_back(model_state);
        pushed_count++;
    endtask

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_sample(input string name, input sample_t actual, input sample_t want);
        if (actual !== want) begin
            errors++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, actual, want);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic want);
        if (actual !== want) begin
            errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, actual, want);
        end
    endtask

    task automatic compare_outputs(input expected_t want);
        check_flag("initialized", initialized, want.initialized);
        check_flag("error", error, want.error);
        check_flag("quat1_valid", quat1_valid, want.quat1_valid);
        check_flag("gyro1_valid", gyro1_valid, want.gyro1_valid);
        check_sample("quat1_w", quat1_w, want.quat1_w);
        check_sample("quat1_x", quat1_x, want.quat1_x);
        check_sample("quat1_y", quat1_y, want.quat1_y);
        check_sample("quat1_z", quat1_z, want.quat1_z);
        check_sample("gyro1_x", gyro1_x, want.gyro1_x);
        check_sample("gyro1_y", gyro1_y, want.gyro1_y);
        check_sample("gyro1_z", gyro1_z, want.gyro1_z);
    endtask

    // Outputs are sampled on the falling edge, well away from the registers
    initial begin : compare_process
        expected_t want;
        forever begin
            wait (checks_done < pushed_count);
            @(negedge clk);
            want = expected_q.pop_front();
            compare_outputs(want);
            checks_done++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    // ========================================
    // Test sequence
    // ========================================

    initial begin : stimulus
        packet_t     pkt;
        byte_t       hdr;
        logic [15:0] pick;
        int          i;
        cs_n = 1'b1;
        ss_n = 1'b1;
        sck  = 1'b0;
        sdi  = 1'b0;
        model_state = '0;
        repeat (16) @(posedge clk);
        cs_n <= 1'b0;
        repeat (4) @(posedge clk);

        // Nothing was received yet so every output is still zero
        expected_q.push_back(model_state);
        pushed_count++;

        // Good packet with both valid flags
        run_packet(build_packet(8'hAA, 16'sd1234, -16'sd2500, 16'sd17999,
                                16'sd300, -16'sd4000, 16'sd5, 8'h03, 16'hBEEF));

        // Each flag on its own and then none
        run_packet(build_packet(8'hAA, -16'sd100, 16'sd200, -16'sd300,
                                16'sd11, 16'sd22, 16'sd33, 8'h01, 16'h0000));
        run_packet(build_packet(8'hAA, 16'sd7, 16'sd8, 16'sd9,
                                -16'sd1, -16'sd2, -16'sd3, 8'h02, 16'h1234));
        run_packet(build_packet(8'hAA, 16'sd32767, -16'sd32768, 16'sd0,
                                16'sd1000, 16'sd2000, 16'sd3000, 8'h00, 16'hFFFF));

        // Bad header keeps the data, then a good one clears the error
        run_packet(build_packet(8'h55, 16'sd1, 16'sd2, 16'sd3,
                                16'sd4, 16'sd5, 16'sd6, 8'h03, 16'h0000));
        run_packet(build_packet(8'hAA, 16'sd4321, 16'sd8765, -16'sd1111,
                                16'sd222, 16'sd333, 16'sd444, 8'h03, 16'hA5A5));

        // About one random packet in four carries a wrong header
        for (i = 0; i < 20; i++) begin
            pick = random_word();
            if (pick[1:0] == 2'b00) begin
                do begin
                    pick = random_word();
                    hdr = pick[7:0];
                end while (hdr == HEADER_BYTE);
            end else begin
                hdr = HEADER_BYTE;
            end
            pick = random_word();
            pkt = build_packet(hdr, random_word(), random_word(), random_word(),
                               random_word(), random_word(), random_word(),
                               pick[7:0], random_word());
            run_packet(pkt);
        end

        wait (checks_done == pushed_count);
        repeat (2) @(posedge clk);
        // Concurrent assertion failures in the capture block count as errors too
        errors += dut0.capture0.props0.fail_count;
        $display("Closing: %0d checks done, %0d errors", checks_done, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/imu_spi_link_properties.sv
`default_nettype none
`timescale 1ns/10ps

// Concurrent checks on the clk side of the packet capture block
module imu_spi_link_properties (
    input wire logic                           clk,
    input wire logic                           cs_n,
    input wire logic                           ss_sync,
    input wire logic                           captured,
    input wire spi_link_pkg::capture_state_t   state
);
    import spi_link_pkg::*;

    // Failed checks so far, added to the error count of the testbench
    int fail_count = 0;

    // The capture strobe never lasts longer than one clk cycle
    property captured_single_cycle;
        @(posedge clk) disable iff (cs_n)
        captured |=> !captured;
    endproperty

    // The strobe trails the copy, so the FSM already sits in holding
    property captured_after_holding;
        @(posedge clk) disable iff (cs_n)
        captured |-> (state == holding);
    endproperty

    // Settling starts only from a select that is already inactive
    property settling_needs_select_high;
        @(posedge clk) disable iff (cs_n)
        (state != settling && !ss_sync) |=> (state != settling);
    endproperty

    captured_pulse_chk: assert property (captured_single_cycle)
        else begin
            fail_count++;
            $error("captured stayed high for more than one clk cycle");
        end

    captured_state_chk: assert property (captured_after_holding)
        else begin
            fail_count++;
            $error("captured was high outside the holding state");
        end

    settling_entry_chk: assert property (settling_needs_select_high)
        else begin
            fail_count++;
            $error("settling was entered while the synchronized select was low");
        end

endmodule

bind frame_capture imu_spi_link_properties props0 (
    .clk      (clk),
    .cs_n     (cs_n),
    .ss_sync  (ss_sync),
    .captured (captured),
    .state    (state)
);

`default_nettype wire

// File: design/imu_spi_link_top.sv
`default_nettype none
`timescale 1ns/10ps

// Read-only SPI target for 16-byte attitude packets from a microcontroller
// Receiver on sck, then capture, decode and output stages on clk
module imu_spi_link_top #(
    parameter int                  SETTLE_CYCLES = 3,
    parameter spi_link_pkg::byte_t HEADER_BYTE   = spi_link_pkg::DEFAULT_HEADER
) (
    input  wire logic             clk,
    input  wire logic             cs_n,
    input  wire logic             ss_n,
    input  wire logic             sck,
    input  wire logic             sdi,
    output logic                  initialized,
    output logic                  error,
    output logic                  quat1_valid,
    output logic                  gyro1_valid,
    output attitude_pkg::sample_t quat1_w,
    output attitude_pkg::sample_t quat1_x,
    output attitude_pkg::sample_t quat1_y,
    output attitude_pkg::sample_t quat1_z,
    output attitude_pkg::sample_t gyro1_x,
    output attitude_pkg::sample_t gyro1_y,
    output attitude_pkg::sample_t gyro1_z
);
    import spi_link_pkg::*;

    // Last packet as written in the sck domain
    packet_t packet_buffer;

    // Copy of the packet in the clk domain
    packet_t snapshot;
    logic    captured;

    // Decoded frame between decoder and output stage
    frame_if frame_bus ();

    spi_frame_receiver receiver0 (
        .sck           (sck),
        .ss_n          (ss_n),
        .sdi           (sdi),
        .cs_n          (cs_n),
        .packet_buffer (packet_buffer)
    );

    frame_capture #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) capture0 (
        .clk           (clk),
        .cs_n          (cs_n),
        .ss_n          (ss_n),
        .packet_buffer (packet_buffer),
        .snapshot      (snapshot),
        .captured      (captured)
    );

    frame_decoder #(
        .HEADER_BYTE (HEADER_BYTE)
    ) decoder0 (
        .clk      (clk),
        .cs_n     (cs_n),
        .snapshot (snapshot),
        .captured (captured),
        .frame    (frame_bus.source)
    );

    attitude_output output0 (
        .clk         (clk),
        .cs_n        (cs_n),
        .frame       (frame_bus.sink),
        .initialized (initialized),
        .error       (error),
        .quat1_valid (quat1_valid),
        .gyro1_valid (gyro1_valid),
        .quat1_w     (quat1_w),
        .quat1_x     (quat1_x),
        .quat1_y     (quat1_y),
        .quat1_z     (quat1_z),
        .gyro1_x     (gyro1_x),
        .gyro1_y     (gyro1_y),
        .gyro1_z     (gyro1_z)
    );

endmodule

`default_nettype wire

// File: design/attitude_output.sv
`default_nettype none
`timescale 1ns/10ps

// Output registers seen by the consumer of the attitude data
// Values hold between frames so the consumer can sample them at any time
module attitude_output (
    input  wire logic      clk,
    input  wire logic      cs_n,
    frame_if.sink          frame,
    output logic           initialized,
    output logic           error,
    output logic           quat1_valid,
    output logic           gyro1_valid,
    output attitude_pkg::sample_t quat1_w,
    output attitude_pkg::sample_t quat1_x,
    output attitude_pkg::sample_t quat1_y,
    output attitude_pkg::sample_t quat1_z,
    output attitude_pkg::sample_t gyro1_x,
    output attitude_pkg::sample_t gyro1_y,
    output attitude_pkg::sample_t gyro1_z
);
    import attitude_pkg::*;

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            initialized <= 1'b0;
            error       <= 1'b0;
            quat1_valid <= 1'b0;
            gyro1_valid <= 1'b0;
            quat1_w     <= '0;
            quat1_x     <= '0;
            quat1_y     <= '0;
            quat1_z     <= '0;
            gyro1_x     <= '0;
            gyro1_y     <= '0;
            gyro1_z     <= '0;
        end else if (frame.new_frame) begin
            if (frame.header_ok) begin
                // Euler angles ride on the vector part with w fixed at one
                quat1_w <= Q14_ONE;
                quat1_x <= frame.roll;
                quat1_y <= frame.pitch;
                quat1_z <= frame.yaw;

                gyro1_x <= frame.gyro_x;
                gyro1_y <= frame.gyro_y;
                gyro1_z <= frame.gyro_z;

                quat1_valid <= frame.flags[EULER_VALID_BIT];
                gyro1_valid <= frame.flags[GYRO_VALID_BIT];

                initialized <= 1'b1;
                error       <= 1'b0;
            end else begin
                // A bad header only changes the status and keeps the last good data
                initialized <= 1'b0;
                error       <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/frame_decoder.sv
`default_nettype none
`timescale 1ns/10ps

// Splits a captured packet into its fields and checks the header byte
module frame_decoder #(
    parameter spi_link_pkg::byte_t HEADER_BYTE = spi_link_pkg::DEFAULT_HEADER
) (
    input  wire logic                  clk,
    input  wire logic                  cs_n,
    input  wire spi_link_pkg::packet_t snapshot,
    input  wire logic                  captured,
    frame_if.source                    frame
);
    import spi_link_pkg::*;
    import attitude_pkg::*;

    // Joins two packet bytes into one field with the MSB byte first
    function automatic sample_t field16(input packet_t pkt, input int pos);
        sample_t value;
        value = {pkt[pos], pkt[pos+1]};
        return value;
    endfunction

    // The strobe trails captured by one cycle so it lines up with the fields
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            frame.new_frame <= 1'b0;
        end else begin
            frame.new_frame <= captured;
        end
    end

    // ========================================
    // Field registers
    // ========================================

    always_ff @(posedge clk) begin
        if (captured) begin
            // This is the single header test in the design
            frame.header_ok <= (snapshot[HEADER_POS] == HEADER_BYTE);

            frame.roll  <= field16(snapshot, ROLL_POS);
            frame.pitch <= field16(snapshot, PITCH_POS);
            frame.yaw   <= field16(snapshot, YAW_POS);

            frame.gyro_x <= field16(snapshot, GYRO_X_POS);
            frame.gyro_y <= field16(snapshot, GYRO_Y_POS);
            frame.gyro_z <= field16(snapshot, GYRO_Z_POS);

            // Bytes 14 and 15 are reserved and not decoded
            frame.flags <= snapshot[FLAGS_POS];
        end
    end

endmodule

`default_nettype wire

// File: design/frame_capture.sv
`default_nettype none
`timescale 1ns/10ps

// Moves a finished packet from the sck domain into the clk domain
// The buffer is copied only after select has been inactive for SETTLE_CYCLES clocks
module frame_capture #(
    parameter int SETTLE_CYCLES = 3
) (
    input  wire logic             clk,
    input  wire logic             cs_n,
    input  wire logic             ss_n,
    input  wire spi_link_pkg::packet_t packet_buffer,
    output spi_link_pkg::packet_t snapshot,
    output logic                  captured
);
    import spi_link_pkg::*;

    localparam int CNT_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(SETTLE_CYCLES - 1);

    // Two flops bring the asynchronous select into the clk domain
    logic ss_meta;
    logic ss_sync;

    capture_state_t state;

    // Number of settle cycles already spent with select high
    logic [CNT_W-1:0] settle_cnt;

    // Goes high in the last settle cycle and triggers the copy
    logic load_snapshot;

    // ========================================
    // Select synchronizer
    // ========================================

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            // Select idles high
            ss_meta <= 1'b1;
            ss_sync <= 1'b1;
        end else begin
            ss_meta <= ss_n;
            ss_sync <= ss_meta;
        end
    end

    assign load_snapshot = (state == settling) && ss_sync && (settle_cnt == LAST_CNT);

    // ========================================
    // Capture FSM
    // ========================================

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            state      <= wait_select;
            settle_cnt <= '0;
            captured   <= 1'b0;
        end else begin
            captured <= load_snapshot;
            case (state)
                wait_select: begin
                    // Nothing is captured before the first real transaction
                    if (!ss_sync) begin
                        state <= receiving;
                    end
                end
                receiving: begin
                    // The transaction ends when the controller releases select
                    if (ss_sync) begin
                        state      <= settling;
                        settle_cnt <= '0;
                    end
                end
                settling: begin
                    if (!ss_sync) begin
                        // Select came back too early so the burst is still running
                        state <= receiving;
                    end else if (load_snapshot) begin
                        state <= holding;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                holding: begin
                    // A new transaction starts with select going low again
                    if (!ss_sync) begin
                        state <= receiving;
                    end
                end
                default: state <= wait_select;
            endcase
        end
    end

    // The sck side is idle at this point so all sixteen bytes are stable
    always_ff @(posedge clk) begin
        if (load_snapshot) begin
            snapshot <= packet_buffer;
        end
    end

endmodule

`default_nettype wire

// File: design/spi_frame_receiver.sv
`default_nettype none
`timescale 1ns/10ps

// SPI mode 0 receiver that runs entirely on the sck clock
// Bits arrive MSB first and are sampled on the rising edge of sck
module spi_frame_receiver (
    input  wire logic            sck,
    input  wire logic            ss_n,
    input  wire logic            sdi,
    input  wire logic            cs_n,
    output spi_link_pkg::packet_t packet_buffer
);
    import spi_link_pkg::*;

    localparam int BYTE_IDX_W = $clog2(PACKET_BYTES);

    // The first seven bits of the current byte
    logic [6:0] shift_reg;

    // Position of the next bit inside the byte
    logic [2:0] bit_cnt;

    // Buffer slot that receives the next completed byte
    logic [BYTE_IDX_W-1:0] byte_cnt;

    // Deselect or system reset restarts the framing
    logic rx_clear;

    assign rx_clear = ss_n | cs_n;

    // ========================================
    // Bit and byte framing
    // ========================================

    always_ff @(posedge sck or posedge rx_clear) begin
        if (rx_clear) begin
            shift_reg <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
        end else begin
            // New bits enter at the LSB so the first bit ends up as the MSB
            shift_reg <= {shift_reg[5:0], sdi};
            bit_cnt   <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                // A full byte moves the write pointer on by one slot
                // After sixteen bytes the pointer wraps and a longer burst overwrites
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Packet buffer
    // ========================================

    // The buffer survives deselect so that the clk side can copy the last packet
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            packet_buffer <= '0;
        end else if (!ss_n && bit_cnt == 3'd7) begin
            // The eighth bit completes the byte in the same edge
            packet_buffer[byte_cnt] <= {shift_reg, sdi};
        end
    end

endmodule

`default_nettype wire

// File: design/frame_if.sv
`default_nettype none
`timescale 1ns/10ps

// One decoded frame travelling from the decoder to the output stage
// The fields are stable while new_frame is high and hold until the next pulse
interface frame_if;
    import attitude_pkg::*;

    // Single-cycle strobe that marks a fresh frame
    logic new_frame;

    // High when byte 0 matched the expected header
    logic header_ok;

    // Euler angles
    sample_t roll;
    sample_t pitch;
    sample_t yaw;

    // Angular rates
    sample_t gyro_x;
    sample_t gyro_y;
    sample_t gyro_z;

    // Raw flags byte
    flags_t flags;

    modport source (
        output new_frame, header_ok, roll, pitch, yaw, gyro_x, gyro_y, gyro_z, flags
    );

    modport sink (
        input new_frame, header_ok, roll, pitch, yaw, gyro_x, gyro_y, gyro_z, flags
    );

endinterface

`default_nettype wire

// File: design/attitude_pkg.sv
`default_nettype none

// Definitions for the decoded attitude and rate data
package attitude_pkg;

    // Angles are scaled by 100 and rates by 2000 on the sender side
    // Both arrive as signed 16-bit integers
    typedef logic signed [15:0] sample_t;

    // The value 1.0 in Q14 format
    // It goes out on the w component since the sender only provides Euler angles
    localparam sample_t Q14_ONE = 16'sd16384;

    // Flags byte from position FLAGS_POS of the packet
    typedef logic [7:0] flags_t;

    // Bit 0 marks the Euler angles as valid
    localparam int EULER_VALID_BIT = 0;

    // Bit 1 marks the gyro rates as valid
    localparam int GYRO_VALID_BIT = 1;

    // The remaining flag bits are reserved and ignored

endpackage

`default_nettype wire

// File: design/spi_link_pkg.sv
`default_nettype none

// Definitions for the SPI link and the layout of one attitude packet
package spi_link_pkg;

    // A packet is always sixteen bytes long
    localparam int PACKET_BYTES = 16;

    // One byte as it comes off the SPI wire
    typedef logic [7:0] byte_t;

    // Whole packet with byte 0 in the lowest index
    typedef byte_t [PACKET_BYTES-1:0] packet_t;

    // Byte positions of the fields inside a packet
    // Every 16-bit field starts with its MSB byte
    localparam int HEADER_POS = 0;
    localparam int ROLL_POS = 1;
    localparam int PITCH_POS = 3;
    localparam int YAW_POS = 5;
    localparam int GYRO_X_POS = 7;
    localparam int GYRO_Y_POS = 9;
    localparam int GYRO_Z_POS = 11;
    localparam int FLAGS_POS = 13;

    // Header value the microcontroller puts in front of every packet
    localparam byte_t DEFAULT_HEADER = 8'hAA;

    // States of the packet capture FSM in the clk domain
    typedef enum logic [1:0] {
        wait_select,
        receiving,
        settling,
        holding
    } capture_state_t;

endpackage

`default_nettype wire
